/* build.f */
+incdir+.
cpuPkg.sv
fetchUnit.sv
instrDecode.sv
regFile.sv
execUnit.sv
resultStage.sv
mipsCore.sv
tb_mipsCore.sv

/* run.sh */
#!/bin/sh
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_mipsCore -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

/* tb_mipsCore.sv */
`include "cpu_settings.svh"

module tb_mipsCore import cpuPkg::*; ();

    localparam int ClkPeriod     = 100;
    localparam int RandomCount   = 2000;                       // Accepted random instructions
    localparam int TimeoutCycles = 3 + 100 + 2 * RandomCount;  // Reset, directed, stall slack
    localparam logic [5:0] OpR    = 6'h00;
    localparam logic [5:0] OpJ    = 6'h02;
    localparam logic [5:0] OpBeq  = 6'h04;
    localparam logic [5:0] OpBne  = 6'h05;
    localparam logic [5:0] OpAddi = 6'h08;
    localparam logic [5:0] OpLw   = 6'h23;
    localparam logic [5:0] OpSw   = 6'h2b;

    logic        Clk;
    logic        arstN;
    word_t       instr;
    logic        instrValid;
    word_t       pc;
    regWrite_t   regCommit;
    store_t      storeCommit;
    word_t       mRegs [32];            // Model register file
    word_t       mMem [2 ** `DMEM_AW];   // Model data memory
    word_t       mPc;
    logic [31:0] lcgState;
    string       testName;

    mipsCore dut_i (
        .Clk         (Clk),
        .arstN       (arstN),
        .instr       (instr),
        .instrValid  (instrValid),
        .pc          (pc),
        .regCommit   (regCommit),
        .storeCommit (storeCommit)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    function automatic int randBelow(input int limit);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'(lcgState[30:16]) % limit;   // Upper bits mix better
    endfunction

    function automatic word_t encodeR(input int rs, input int rt, input int rd, input int funct);
        return {OpR, regAddr_t'(rs), regAddr_t'(rt), regAddr_t'(rd), 5'd0, 6'(funct)};
    endfunction

    function automatic word_t encodeI(input logic [5:0] op, input int rs, input int rt,
                                      input int imm);
        return {op, regAddr_t'(rs), regAddr_t'(rt), imm16_t'(imm)};
    endfunction

    // Executes one instruction on the model state by MIPS rules
    function automatic void modelExecute(input word_t ins, input logic valid,
                                         output regWrite_t expReg, output store_t expStore,
                                         output word_t expNextPc);
        word_t a;
        word_t b;
        word_t simm;
        word_t ea;
        word_t seqPc;
        a         = mRegs[ins[25:21]];
        b         = mRegs[ins[20:16]];
        simm      = {{16{ins[15]}}, ins[15:0]};
        ea        = a + simm;                   // Load/store byte address
        seqPc     = mPc + 32'd4;
        expReg    = '0;
        expStore  = '0;
        expNextPc = seqPc;
        case (ins[31:26])
            OpR: begin
                expReg = {1'b1, ins[15:11], 32'd0};
                case (ins[5:0])
                    6'h20:   expReg.data = a + b;
                    6'h22:   expReg.data = a - b;
                    6'h24:   expReg.data = a & b;
                    6'h25:   expReg.data = a | b;
                    6'h2a:   expReg.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: expReg.valid = 1'b0;   // Unsupported funct
                endcase
            end
            OpAddi:  expReg = {1'b1, ins[20:16], ea};
            OpLw:    expReg = {1'b1, ins[20:16], mMem[ea[`DMEM_AW+1:2]]};
            OpSw:    expStore = {1'b1, ea, b};
            OpBeq:   expNextPc = (a == b) ? seqPc + (simm << 2) : seqPc;
            OpBne:   expNextPc = (a != b) ? seqPc + (simm << 2) : seqPc;
            OpJ:     expNextPc = {seqPc[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        if (expReg.addr == 5'd0 || !valid) expReg.valid = 1'b0;
        if (!valid) begin
            expStore.valid = 1'b0;
            expNextPc      = mPc;   // Stall holds pc
        end
    endfunction

    task automatic checkField(input string field, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %0h actual %0h", testName, field, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Checks this cycle's outputs and retires the instruction in the model
    always @(posedge Clk) begin
        regWrite_t expReg;
        store_t    expStore;
        word_t     expNextPc;
        if (!arstN) begin
            mPc = `RESET_PC;
            foreach (mRegs[i]) mRegs[i] = '0;
            foreach (mMem[i]) mMem[i] = '0;
        end else begin
            modelExecute(instr, instrValid, expReg, expStore, expNextPc);
            checkField("pc", 64'(mPc), 64'(pc));
            checkField("reg valid", 64'(expReg.valid), 64'(regCommit.valid));
            if (expReg.valid) begin
                checkField("reg addr", 64'(expReg.addr), 64'(regCommit.addr));
                checkField("reg data", 64'(expReg.data), 64'(regCommit.data));
                mRegs[expReg.addr] = expReg.data;
            end
            checkField("store valid", 64'(expStore.valid), 64'(storeCommit.valid));
            if (expStore.valid) begin
                checkField("store addr", 64'(expStore.addr), 64'(storeCommit.addr));
                checkField("store data", 64'(expStore.data), 64'(storeCommit.data));
                mMem[expStore.addr[`DMEM_AW+1:2]] = expStore.data;
            end
            mPc = expNextPc;
        end
    end

    function automatic word_t randomInstr();
        int    functs [5] = '{'h20, 'h22, 'h24, 'h25, 'h2a};
        int    rs;
        int    rt;
        int    rd;
        int    kind;
        word_t ins;
        rs   = randBelow(8);   // Small register pool for reuse
        rt   = randBelow(8);
        rd   = randBelow(8);
        kind = randBelow(12);
        case (kind)
            0, 1, 2, 3, 4: ins = encodeR(rs, rt, rd, functs[kind]);
            5:       ins = encodeI(OpAddi, rs, rt, randBelow(32768) - 16384);
            6:       ins = encodeI(OpLw, rs, rt, randBelow(512) - 256);
            7:       ins = encodeI(OpSw, rs, rt, randBelow(512) - 256);
            8:       ins = encodeI(OpBeq, rs, rt, randBelow(16) - 8);
            9:       ins = encodeI(OpBne, rs, rt, randBelow(16) - 8);
            10:      ins = {OpJ, jTarget_t'(randBelow(32768))};
            default: ins = (randBelow(2) == 0) ? encodeR(rs, rt, rd, 'h00)   // sll
                                               : encodeI(6'h0d, rs, rt, 3);  // ori
        endcase
        return ins;
    endfunction

    task automatic issue(input string name, input word_t ins, input logic valid);
        @(negedge Clk);
        testName   = name;
        instr      = ins;
        instrValid = valid;
    endtask

    initial begin
        int   accepted;
        logic valid;
        Clk        = 1'b0;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        lcgState   = 32'h2fbe;
        testName   = "reset";
        repeat (3) @(negedge Clk);
        arstN = 1'b1;
        checkField("pc", 64'(`RESET_PC), 64'(pc));
        checkField("reg valid", 64'(0), 64'(regCommit.valid));
        checkField("store valid", 64'(0), 64'(storeCommit.valid));
        issue("arith", encodeI(OpAddi, 0, 1, 5), 1'b1);
        issue("arith", encodeI(OpAddi, 0, 2, -3), 1'b1);
        issue("arith", encodeR(1, 2, 3, 'h20), 1'b1);
        issue("arith", encodeR(1, 2, 4, 'h22), 1'b1);
        issue("arith", encodeR(1, 2, 5, 'h24), 1'b1);
        issue("arith", encodeR(1, 2, 6, 'h25), 1'b1);
        issue("arith", encodeR(2, 1, 7, 'h2a), 1'b1);     // -3 < 5 only when signed
        issue("arith", encodeI(OpAddi, 1, 0, 7), 1'b1);   // r0 target
        issue("memory", encodeI(OpSw, 0, 4, 8), 1'b1);
        issue("memory", encodeI(OpLw, 0, 5, 8), 1'b1);
        issue("memory", encodeI(OpSw, 0, 3, 260), 1'b1);  // Wraps to word 1
        issue("memory", encodeI(OpLw, 0, 6, 4), 1'b1);
        issue("control", encodeI(OpBeq, 4, 4, 3), 1'b1);
        issue("control", encodeI(OpBeq, 1, 2, 2), 1'b1);
        issue("control", encodeI(OpBne, 1, 2, -4), 1'b1); // Backwards
        issue("control", {OpJ, 26'h0000400}, 1'b1);
        issue("stall", encodeI(OpSw, 0, 1, 0), 1'b0);
        issue("stall", {OpJ, 26'h0001234}, 1'b0);
        issue("stall", encodeI(OpAddi, 1, 1, 1), 1'b1);
        accepted = 0;
        while (accepted < RandomCount) begin
            valid = randBelow(100) < 80;
            issue("random", randomInstr(), valid);
            if (valid) accepted++;
        end
        issue("drain", '0, 1'b0);   // Idle edge checks the final pc
        @(negedge Clk);
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

/* mipsCore.sv */
module mipsCore import cpuPkg::*; (
    input  logic      Clk,
    input  logic      arstN,
    input  word_t     instr,         // Fetched at pc, same cycle
    input  logic      instrValid,    // Low stalls the core
    output word_t     pc,
    output regWrite_t regCommit,
    output store_t    storeCommit
);

    word_t    pcPlus4;
    word_t    branchTarget;
    logic     branchTaken;
    decoded_t decoded;
    regAddr_t rs;
    regAddr_t rt;
    word_t    rsData;
    word_t    rtData;
    word_t    aluResult;

    fetchUnit fetchU (
        .Clk          (Clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    instrDecode decodeU (
        .instr         (instr),
        .regInstrValid (instrValid),   // Gates both write enables
        .decoded       (decoded),
        .rs            (rs),
        .rt            (rt)
    );

    regFile regFileU (
        .Clk       (Clk),
        .arstN     (arstN),
        .rs        (rs),
        .rt        (rt),
        .rsData    (rsData),
        .rtData    (rtData),
        .regCommit (regCommit)   // Write-back loops here
    );

    execUnit execU (
        .rsData       (rsData),
        .rtData       (rtData),
        .decoded      (decoded),
        .pcPlus4      (pcPlus4),
        .aluResult    (aluResult),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    resultStage resultU (
        .Clk         (Clk),
        .arstN       (arstN),
        .decoded     (decoded),
        .aluResult   (aluResult),
        .rtData      (rtData),
        .regCommit   (regCommit),
        .storeCommit (storeCommit)
    );

endmodule

/* resultStage.sv */
`include "cpu_settings.svh"

module resultStage import cpuPkg::*; (
    input  logic      Clk,
    input  logic      arstN,
    input  decoded_t  decoded,
    input  word_t     aluResult,     // Result or effective address
    input  word_t     rtData,        // Store data
    output regWrite_t regCommit,
    output store_t    storeCommit
);

    localparam int DmemWords = 2 ** `DMEM_AW;

    word_t                dmem [DmemWords];
    logic [`DMEM_AW-1:0]  wordIdx;
    word_t                loadData;

    // Byte offset dropped, upper bits wrap
    assign wordIdx  = aluResult[`DMEM_AW+1:2];
    assign loadData = dmem[wordIdx];   // Combinational read

    // Commit records for this cycle's instruction
    assign regCommit.valid = decoded.ctrl.regWrite;   // Already qualified in decode
    assign regCommit.addr  = decoded.dest;
    assign regCommit.data  = decoded.ctrl.memToReg ? loadData : aluResult;

    assign storeCommit.valid = decoded.ctrl.memWrite;
    assign storeCommit.addr  = aluResult;
    assign storeCommit.data  = rtData;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeCommit.valid) begin
            dmem[wordIdx] <= storeCommit.data;   // sw lands on the edge
        end
    end

endmodule

/* execUnit.sv */
`include "cpu_settings.svh"

module execUnit import cpuPkg::*; (
    input  word_t    rsData,
    input  word_t    rtData,
    input  decoded_t decoded,
    input  word_t    pcPlus4,
    output word_t    aluResult,
    output logic     branchTaken,
    output word_t    branchTarget
);

    word_t opB;
    logic  operandsEqual;
    word_t branchOffset;
    word_t jumpAddr;
    logic  condTaken;

    assign opB = decoded.ctrl.aluSrc ? decoded.immExt : rtData;   // I-type uses imm

    // Plain-operator ALU
    always_comb begin
        case (decoded.ctrl.aluOp)
            aluAnd:  aluResult = rsData & opB;
            aluOr:   aluResult = rsData | opB;
            aluAdd:  aluResult = rsData + opB;
            aluSub:  aluResult = rsData - opB;
            aluSlt:  aluResult = word_t'($signed(rsData) < $signed(opB));   // Signed compare
            default: aluResult = '0;
        endcase
    end

    // Branch decision straight from the register values
    assign operandsEqual = (rsData == rtData);
    assign condTaken     = (decoded.ctrl.beq && operandsEqual)
                        || (decoded.ctrl.bne && !operandsEqual);

    assign branchOffset = {decoded.immExt[`WORD_W-3:0], 2'b00};    // Word offset to bytes
    assign jumpAddr     = {pcPlus4[`WORD_W-1:`WORD_W-4], decoded.jTarget, 2'b00};

    // Jump target only matters when jump is set
    assign branchTarget = decoded.ctrl.jump ? jumpAddr : pcPlus4 + branchOffset;
    assign branchTaken  = decoded.ctrl.jump || condTaken;

endmodule

/* regFile.sv */
`include "cpu_settings.svh"

module regFile import cpuPkg::*; (
    input  logic      Clk,
    input  logic      arstN,
    input  regAddr_t  rs,
    input  regAddr_t  rt,
    output word_t     rsData,
    output word_t     rtData,
    input  regWrite_t regCommit   // Write port from write-back
);

    localparam int NumRegs = 2 ** `REG_AW;

    word_t regs [NumRegs];

    // r0 reads as zero regardless of contents
    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regCommit.valid && (regCommit.addr != '0)) begin
            regs[regCommit.addr] <= regCommit.data;   // Rising-edge write
        end
    end

endmodule

/* instrDecode.sv */
`include "cpu_settings.svh"

module instrDecode import cpuPkg::*; (
    input  word_t    instr,
    input  logic     regInstrValid,   // Fetch port qualifier
    output decoded_t decoded,
    output regAddr_t rs,
    output regAddr_t rt
);

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rd;
    imm16_t   imm;
    ctrl_t    ctrl;
    logic     useRd;       // R-type writes rd
    regAddr_t dest;

    assign opcode = opcode_t'(instr[31:26]);  // Unknown codes hit default
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];

    // Control decoder, everything off unless the opcode says otherwise
    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        useRd      = 1'b0;
        case (opcode)
            opR: begin
                useRd = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl.regWrite = 1'b0;   // Unknown funct is a no-op
                endcase
            end
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;   // Base plus offset
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.beq   = 1'b1;
                ctrl.aluOp = aluSub;
            end
            opBne: begin
                ctrl.bne   = 1'b1;
                ctrl.aluOp = aluSub;
            end
            opJ:     ctrl.jump = 1'b1;
            default: ;                  // Falls through to PC+4
        endcase
    end

    assign dest = useRd ? rd : rt;

    // Writes need a live instruction, r0 never commits
    always_comb begin
        decoded          = '0;
        decoded.ctrl     = ctrl;
        decoded.ctrl.regWrite = ctrl.regWrite && regInstrValid && (dest != '0);
        decoded.ctrl.memWrite = ctrl.memWrite && regInstrValid;
        decoded.dest     = dest;
        decoded.immExt   = {{(`WORD_W - 16){imm[15]}}, imm};   // Sign extend
        decoded.jTarget  = instr[25:0];
    end

endmodule

/* fetchUnit.sv */
`include "cpu_settings.svh"

module fetchUnit import cpuPkg::*; (
    input  logic  Clk,
    input  logic  arstN,
    input  logic  instrValid,    // Instruction retires this cycle
    input  logic  branchTaken,   // Taken branch or jump
    input  word_t branchTarget,
    output word_t pc,
    output word_t pcPlus4
);

    word_t nextPc;

    assign pcPlus4 = pc + word_t'(4);                        // Sequential successor
    assign nextPc  = branchTaken ? branchTarget : pcPlus4;   // Redirect wins

    // PC only moves on an accepted instruction
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (instrValid) begin
            pc <= nextPc;
        end
    end

endmodule

/* cpuPkg.sv */
`include "cpu_settings.svh"

package cpuPkg;

    typedef logic [`WORD_W-1:0] word_t;        // Data or address word
    typedef logic [`REG_AW-1:0] regAddr_t;     // Register number
    typedef logic [15:0]        imm16_t;       // I-type immediate field
    typedef logic [25:0]        jTarget_t;     // J-type target field

    // Primary opcodes of the retained subset
    typedef enum logic [5:0] {
        opR    = 6'b000000,
        opJ    = 6'b000010,
        opBeq  = 6'b000100,
        opBne  = 6'b000101,
        opAddi = 6'b001000,
        opLw   = 6'b100011,
        opSw   = 6'b101011
    } opcode_t;

    // R-type funct codes
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } funct_t;

    // ALU control, classic MIPS encoding
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOp_t;

    typedef struct packed {
        logic   aluSrc;     // Immediate as operand B
        logic   memWrite;   // Store to data memory
        logic   memToReg;   // Load data goes to register
        logic   regWrite;   // Register commit
        logic   beq;
        logic   bne;
        logic   jump;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        regAddr_t dest;     // rd or rt
        word_t    immExt;   // Sign-extended immediate
        jTarget_t jTarget;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        regAddr_t addr;
        word_t    data;
    } regWrite_t;

    typedef struct packed {
        logic  valid;
        word_t addr;        // Byte address from the ALU
        word_t data;
    } store_t;

endpackage

/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and address widths
`define WORD_W 32       // Data and address word
`define REG_AW 5        // Register number

// First fetch address after reset
`define RESET_PC 32'h1000

// Data memory holds 2**DMEM_AW words
`define DMEM_AW 6

`endif
